//--- common/lnkbank_config.svh
// Size macros for the linked-list message bank
// Included by the package, the RTL and the testbench

`ifndef LNKBANK_CONFIG_SVH
`define LNKBANK_CONFIG_SVH

////////////////////////////////////////
// Identifiers
////////////////////////////////////////

// One ordered list per AXI identifier
`define LNKBANK_NUM_IDS 4
`define LNKBANK_ID_W 2

////////////////////////////////////////
// Storage
////////////////////////////////////////

// Slots shared by all identifiers
`define LNKBANK_DEPTH 8
`define LNKBANK_ADDR_W 3
`define LNKBANK_PAYLOAD_W 8

`endif

//--- common/lnkbank_pkg.sv
// Types shared by the message bank and its testbench
// Sizes come from the config header

`include "lnkbank_config.svh"

package lnkbank_pkg;

  // Scalar fields
  typedef logic [`LNKBANK_ID_W-1:0] id_t;
  typedef logic [`LNKBANK_ADDR_W-1:0] addr_t;
  typedef logic [`LNKBANK_PAYLOAD_W-1:0] payload_t;

  // One extra bit so a completely full list still fits
  typedef logic [`LNKBANK_ADDR_W:0] len_t;

  // Message as seen on both the input and the output side
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

  // Word of the metadata RAM, link to the following element
  typedef struct packed {
    addr_t nxt;
  } next_ptr_t;

  // RAM port requests
  typedef struct packed {
    logic  en;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } wr_req_t;

endpackage

//--- rtl/lnkbank_ram.sv
// Behavioral two-port RAM, one write port and one registered read port
// The word type is a parameter so payload and link storage share this code

`include "lnkbank_config.svh"

module lnkbank_ram #(
  parameter type data_t = logic,
  parameter int unsigned depth = `LNKBANK_DEPTH
) (
  input  logic                 clk_i,

  // Write port
  input  lnkbank_pkg::wr_req_t i_wr,
  input  data_t                i_wdata,

  // Read port, data one cycle after the request
  input  lnkbank_pkg::rd_req_t i_rd,
  output data_t                o_rdata
);

  data_t mem [depth];

  // Synchronous write
  always_ff @(posedge clk_i) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wdata;
    end
  end

  // Registered read, returns the old word on a same-cycle collision
  // Data holds while no read is requested
  always_ff @(posedge clk_i) begin
    if (i_rd.en) begin
      o_rdata <= mem[i_rd.addr];
    end
  end

endmodule

//--- lnkbank/lnkbank_free_slots.sv
// Slot occupancy of the message bank
// Gives the lowest free slot for the next write and flags a full bank

`include "lnkbank_config.svh"

module lnkbank_free_slots (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Slot taken by an accepted message
  input  logic               i_alloc,
  input  lnkbank_pkg::addr_t i_alloc_addr,

  // Slot freed by an output handshake
  input  logic               i_release,
  input  lnkbank_pkg::addr_t i_release_addr,

  output lnkbank_pkg::addr_t o_free_addr,
  output logic               o_full
);

  // One valid bit per slot
  logic [`LNKBANK_DEPTH-1:0] slot_v_q;
  logic [`LNKBANK_DEPTH-1:0] slot_v_d;

  // Set on allocation, clear on release
  always_comb begin
    slot_v_d = slot_v_q;
    if (i_alloc) begin
      slot_v_d[i_alloc_addr] = 1'b1;
    end
    if (i_release) begin
      slot_v_d[i_release_addr] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q <= '0;
    end else begin
      slot_v_q <= slot_v_d;
    end
  end

  // Priority search, downward scan so the lowest clear slot wins
  always_comb begin
    o_free_addr = '0;
    for (int k = `LNKBANK_DEPTH - 1; k >= 0; k--) begin
      if (!slot_v_q[k]) begin
        o_free_addr = lnkbank_pkg::addr_t'(k);
      end
    end
  end

  assign o_full = &slot_v_q;

endmodule

//--- lnkbank/lnkbank_queue_ptrs.sv
// Per-identifier list pointers of the message bank
// Tracks head, tail, next-tail and length and drives the RAM writes
// An empty list keeps its pointers on the lowest free slot

`include "lnkbank_config.svh"

module lnkbank_queue_ptrs (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Input handshake and the slot it fills
  input  logic                   i_push,
  input  lnkbank_pkg::id_t       i_push_id,
  input  lnkbank_pkg::addr_t     i_free_addr,

  // Output handshake from the arbiter
  input  logic                   i_pop,
  input  lnkbank_pkg::id_t       i_pop_id,

  // Link read back one cycle after a pop
  input  lnkbank_pkg::next_ptr_t i_meta_rdata,

  output lnkbank_pkg::wr_req_t   o_payload_wr,
  output lnkbank_pkg::wr_req_t   o_meta_wr,
  output lnkbank_pkg::next_ptr_t o_meta_wdata,
  output lnkbank_pkg::rd_req_t   o_meta_rd,

  // State seen by the arbiter
  output lnkbank_pkg::addr_t     o_tails [`LNKBANK_NUM_IDS],
  output lnkbank_pkg::addr_t     o_next_tails [`LNKBANK_NUM_IDS],
  output lnkbank_pkg::len_t      o_len_after_pop [`LNKBANK_NUM_IDS]
);

  ////////////////////////////////////////
  // Pointer state
  ////////////////////////////////////////

  // Head is the newest slot, tail the oldest, next-tail the one after it
  lnkbank_pkg::addr_t head_q [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t head_d [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t tail_q [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t tail_d [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t next_tail_q [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t next_tail_d [`LNKBANK_NUM_IDS];
  // Next-tail with the pending RAM reload applied
  lnkbank_pkg::addr_t next_tail_eff [`LNKBANK_NUM_IDS];

  lnkbank_pkg::len_t  len_q [`LNKBANK_NUM_IDS];
  lnkbank_pkg::len_t  len_d [`LNKBANK_NUM_IDS];
  lnkbank_pkg::len_t  len_after_pop [`LNKBANK_NUM_IDS];

  // Next-tail must come from the metadata RAM in the following cycle
  logic [`LNKBANK_NUM_IDS-1:0] reload_q;
  logic [`LNKBANK_NUM_IDS-1:0] reload_d;

  always_comb begin
    for (int i = 0; i < `LNKBANK_NUM_IDS; i++) begin
      next_tail_eff[i] = reload_q[i] ? i_meta_rdata.nxt : next_tail_q[i];

      if (i_pop && i_pop_id == lnkbank_pkg::id_t'(i)) begin
        len_after_pop[i] = len_q[i] - lnkbank_pkg::len_t'(1);
      end else begin
        len_after_pop[i] = len_q[i];
      end

      if (i_push && i_push_id == lnkbank_pkg::id_t'(i)) begin
        len_d[i]  = len_after_pop[i] + lnkbank_pkg::len_t'(1);
        head_d[i] = i_free_addr;
      end else begin
        len_d[i]  = len_after_pop[i];
        head_d[i] = head_q[i];
      end

      // Two or more left after a pop, fetch the new next-tail link
      reload_d[i] = i_pop && i_pop_id == lnkbank_pkg::id_t'(i) &&
                    len_after_pop[i] >= lnkbank_pkg::len_t'(2);

      if (len_after_pop[i] == '0) begin
        // Empty list, everything sits on the free slot
        head_d[i]      = i_free_addr;
        tail_d[i]      = i_free_addr;
        next_tail_d[i] = i_free_addr;
      end else begin
        // Pop moves the tail one element ahead
        tail_d[i] = (i_pop && i_pop_id == lnkbank_pkg::id_t'(i)) ? next_tail_eff[i] : tail_q[i];
        // Single element left, next-tail waits for the next push
        if (len_after_pop[i] == lnkbank_pkg::len_t'(1)) begin
          next_tail_d[i] = i_free_addr;
        end else begin
          next_tail_d[i] = next_tail_eff[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q      <= '{default: '0};
      tail_q      <= '{default: '0};
      next_tail_q <= '{default: '0};
      len_q       <= '{default: '0};
      reload_q    <= '0;
    end else begin
      head_q      <= head_d;
      tail_q      <= tail_d;
      next_tail_q <= next_tail_d;
      len_q       <= len_d;
      reload_q    <= reload_d;
    end
  end

  ////////////////////////////////////////
  // RAM requests
  ////////////////////////////////////////

  always_comb begin
    // Payload goes to the free slot
    o_payload_wr.en   = i_push;
    o_payload_wr.addr = i_free_addr;
    // Link the old head to the new slot if the list stays non-empty
    o_meta_wr.en      = i_push && len_after_pop[i_push_id] != '0;
    o_meta_wr.addr    = head_q[i_push_id];
    o_meta_wdata.nxt  = i_free_addr;
    // Read the link of the element that becomes the tail
    o_meta_rd.en      = i_pop && len_after_pop[i_pop_id] >= lnkbank_pkg::len_t'(2);
    o_meta_rd.addr    = next_tail_eff[i_pop_id];
  end

  assign o_tails         = tail_q;
  assign o_next_tails    = next_tail_eff;
  assign o_len_after_pop = len_after_pop;

endmodule

//--- lnkbank/lnkbank_release_arb.sv
// Output arbiter of the message bank
// Picks the lowest non-empty identifier, issues the payload read and
// holds the presented identifier and slot until the output handshake

`include "lnkbank_config.svh"

module lnkbank_release_arb (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 i_out_ready,

  // List state after this cycle's pop
  input  lnkbank_pkg::addr_t   i_tails [`LNKBANK_NUM_IDS],
  input  lnkbank_pkg::addr_t   i_next_tails [`LNKBANK_NUM_IDS],
  input  lnkbank_pkg::len_t    i_len_after_pop [`LNKBANK_NUM_IDS],

  output lnkbank_pkg::rd_req_t o_payload_rd,
  output logic                 o_pop,
  output lnkbank_pkg::id_t     o_pop_id,
  output lnkbank_pkg::addr_t   o_release_addr,
  output logic                 o_out_valid,
  output lnkbank_pkg::id_t     o_out_id
);

  // Presented message
  logic               out_valid_q;
  lnkbank_pkg::id_t   out_id_q;
  lnkbank_pkg::addr_t out_addr_q;

  // Choice for the next cycle
  logic               sel_valid;
  lnkbank_pkg::id_t   sel_id;
  lnkbank_pkg::addr_t sel_addr;

  assign o_pop = out_valid_q && i_out_ready;

  // Downward scan so the lowest non-empty identifier wins
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;
    sel_addr  = '0;
    for (int i = `LNKBANK_NUM_IDS - 1; i >= 0; i--) begin
      if (i_len_after_pop[i] != '0) begin
        sel_valid = 1'b1;
        sel_id    = lnkbank_pkg::id_t'(i);
        // Tail is leaving now, its successor is next in line
        if (o_pop && out_id_q == lnkbank_pkg::id_t'(i)) begin
          sel_addr = i_next_tails[i];
        end else begin
          sel_addr = i_tails[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_id_q    <= '0;
      out_addr_q  <= '0;
    end else begin
      out_valid_q <= sel_valid;
      out_id_q    <= sel_id;
      out_addr_q  <= sel_addr;
    end
  end

  // Payload arrives with the registered choice
  assign o_payload_rd.en   = sel_valid;
  assign o_payload_rd.addr = sel_addr;

  assign o_pop_id       = out_id_q;
  assign o_release_addr = out_addr_q;
  assign o_out_valid    = out_valid_q;
  assign o_out_id       = out_id_q;

endmodule

//--- lnkbank/lnkbank_top.sv
// Linked-list message bank, top level
// Messages share one payload RAM and form one ordered list per identifier
// Output presents the oldest message of the lowest non-empty identifier

`include "lnkbank_config.svh"

module lnkbank_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Input side
  input  logic              i_in_valid,
  input  lnkbank_pkg::msg_t i_in_msg,
  output logic              o_in_ready,

  // Output side
  output logic              o_out_valid,
  output lnkbank_pkg::msg_t o_out_msg,
  input  logic              i_out_ready
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  lnkbank_pkg::addr_t     free_addr;
  logic                   full;
  logic                   push;
  logic                   pop;
  lnkbank_pkg::id_t       pop_id;
  lnkbank_pkg::addr_t     release_addr;
  lnkbank_pkg::id_t       out_id;

  // RAM ports
  lnkbank_pkg::wr_req_t   payload_wr;
  lnkbank_pkg::rd_req_t   payload_rd;
  lnkbank_pkg::payload_t  payload_rdata;
  lnkbank_pkg::wr_req_t   meta_wr;
  lnkbank_pkg::next_ptr_t meta_wdata;
  lnkbank_pkg::rd_req_t   meta_rd;
  lnkbank_pkg::next_ptr_t meta_rdata;

  // Per-identifier list state
  lnkbank_pkg::addr_t     tails [`LNKBANK_NUM_IDS];
  lnkbank_pkg::addr_t     next_tails [`LNKBANK_NUM_IDS];
  lnkbank_pkg::len_t      len_after_pop [`LNKBANK_NUM_IDS];

  // Ready depends on valid, refused when full or while a message leaves
  assign o_in_ready = i_in_valid && !full && !pop;
  assign push       = i_in_valid && o_in_ready;

  assign o_out_msg.id      = out_id;
  assign o_out_msg.payload = payload_rdata;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  lnkbank_ram #(.data_t(lnkbank_pkg::payload_t)) u_payload_ram (
    .clk_i, .i_wr(payload_wr), .i_wdata(i_in_msg.payload), .i_rd(payload_rd), .o_rdata(payload_rdata)
  );

  lnkbank_ram #(.data_t(lnkbank_pkg::next_ptr_t)) u_meta_ram (
    .clk_i, .i_wr(meta_wr), .i_wdata(meta_wdata), .i_rd(meta_rd), .o_rdata(meta_rdata)
  );

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  lnkbank_free_slots u_free_slots (
    .clk_i, .rst_ni,
    .i_alloc(push), .i_alloc_addr(free_addr),
    .i_release(pop), .i_release_addr(release_addr),
    .o_free_addr(free_addr), .o_full(full)
  );

  lnkbank_queue_ptrs u_queue_ptrs (
    .clk_i, .rst_ni,
    .i_push(push), .i_push_id(i_in_msg.id), .i_free_addr(free_addr),
    .i_pop(pop), .i_pop_id(pop_id), .i_meta_rdata(meta_rdata),
    .o_payload_wr(payload_wr), .o_meta_wr(meta_wr), .o_meta_wdata(meta_wdata), .o_meta_rd(meta_rd),
    .o_tails(tails), .o_next_tails(next_tails), .o_len_after_pop(len_after_pop)
  );

  lnkbank_release_arb u_release_arb (
    .clk_i, .rst_ni, .i_out_ready,
    .i_tails(tails), .i_next_tails(next_tails), .i_len_after_pop(len_after_pop),
    .o_payload_rd(payload_rd), .o_pop(pop), .o_pop_id(pop_id), .o_release_addr(release_addr),
    .o_out_valid(o_out_valid), .o_out_id(out_id)
  );

endmodule

//--- sim/lnkbank_checks.svh
// Compare tasks of the message bank testbench, typed to the DUT ports
// Included inside the testbench module, reports through its fail_run task

`ifndef LNKBANK_CHECKS_SVH
`define LNKBANK_CHECKS_SVH

////////////////////////////////////////
// Output side
////////////////////////////////////////

// Whole message, identifier and payload together
task automatic check_msg(
  input string             name,
  input lnkbank_pkg::msg_t exp,
  input lnkbank_pkg::msg_t got
);
  if (got !== exp) begin
    fail_run($sformatf(
      "MISMATCH at %0d ns: %s expected id %0d payload %02h, got id %0d payload %02h",
      $time, name, exp.id, exp.payload, got.id, got.payload));
  end
endtask

// Presence of a message on the output
task automatic check_valid(input logic exp, input logic got);
  if (got !== exp) begin
    fail_run($sformatf("MISMATCH at %0d ns: o_out_valid expected %b, got %b",
                       $time, exp, got));
  end
endtask

////////////////////////////////////////
// Input side
////////////////////////////////////////

task automatic check_ready(input logic exp, input logic got);
  if (got !== exp) begin
    fail_run($sformatf("MISMATCH at %0d ns: o_in_ready expected %b, got %b",
                       $time, exp, got));
  end
endtask

`endif

//--- sim/tb_lnkbank.sv
// Testbench for the linked-list message bank
// Replays sim/lnkbank_vectors.txt against a queue model per identifier
// Run from the project root so the vector file is found

`include "lnkbank_config.svh"

module tb_lnkbank;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 8;
  // Phase whose lines get random idle gaps
  localparam int RANDOM_PHASE = 5;

  // One clock cycle of stimulus from a D line
  typedef struct packed {
    int unsigned       phase;
    logic              valid;
    lnkbank_pkg::msg_t msg;
    logic              ready;
  } drive_t;

  // Expected output of an E line in delivery order within its phase
  typedef struct packed {
    int unsigned       phase;
    lnkbank_pkg::msg_t msg;
  } expect_t;

  logic              clk_i;
  logic              rst_ni;
  logic              i_in_valid;
  lnkbank_pkg::msg_t i_in_msg;
  logic              o_in_ready;
  logic              o_out_valid;
  lnkbank_pkg::msg_t o_out_msg;
  logic              i_out_ready;

  drive_t      drives [$];
  expect_t     expects [$];
  int unsigned line_count;
  logic        loaded;

  // Reference model with the payloads of each identifier in push order
  lnkbank_pkg::payload_t model_q [`LNKBANK_NUM_IDS][$];
  int unsigned           held;
  // A push is first shown two cycles later, so the latest one is not yet eligible
  logic                  last_push;
  lnkbank_pkg::id_t      last_push_id;
  // Messages delivered in the current phase
  lnkbank_pkg::msg_t     seen [$];

  lnkbank_top uut (
    .clk_i,
    .rst_ni,
    .i_in_valid,
    .i_in_msg,
    .o_in_ready,
    .o_out_valid,
    .o_out_msg,
    .i_out_ready
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Run stopped on the first error");
  endtask

  `include "lnkbank_checks.svh"

  ////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////

  // D lines drive one cycle and E lines list expected outputs
  task automatic load_vectors();
    int      fd;
    string   line;
    int      f_phase, f_valid, f_id, f_payload, f_ready;
    drive_t  d;
    expect_t e;
    fd = $fopen("sim/lnkbank_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open the vector file sim/lnkbank_vectors.txt");
    end
    line_count = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) == "D") begin
        if ($sscanf(line.substr(1, line.len() - 1), "%d %d %d %h %d",
                    f_phase, f_valid, f_id, f_payload, f_ready) != 5) begin
          fail_run({"Malformed drive line in the vector file: ", line});
        end
        d.phase       = f_phase;
        d.valid       = (f_valid != 0);
        d.msg.id      = lnkbank_pkg::id_t'(f_id);
        d.msg.payload = lnkbank_pkg::payload_t'(f_payload);
        d.ready       = (f_ready != 0);
        drives.push_back(d);
        line_count++;
      end else if (line.getc(0) == "E") begin
        if ($sscanf(line.substr(1, line.len() - 1), "%d %d %h",
                    f_phase, f_id, f_payload) != 3) begin
          fail_run({"Malformed expect line in the vector file: ", line});
        end
        e.phase       = f_phase;
        e.msg.id      = lnkbank_pkg::id_t'(f_id);
        e.msg.payload = lnkbank_pkg::payload_t'(f_payload);
        expects.push_back(e);
        line_count++;
      end
    end
    $fclose(fd);
    loaded = 1'b1;
  endtask

  ////////////////////////////////////////
  // Cycle driver and scoreboard
  ////////////////////////////////////////

  // Handshakes are judged mid-cycle where inputs and outputs are stable
  task automatic observe_cycle();
    logic              exp_valid;
    logic              exp_ready;
    lnkbank_pkg::msg_t exp_msg;
    int unsigned       eligible;
    exp_valid = 1'b0;
    exp_msg   = '0;
    // Oldest message of the lowest identifier with an eligible message
    for (int i = 0; i < `LNKBANK_NUM_IDS && !exp_valid; i++) begin
      eligible = model_q[i].size();
      if (last_push && last_push_id == lnkbank_pkg::id_t'(i)) begin
        eligible--;
      end
      if (eligible != 0) begin
        exp_valid       = 1'b1;
        exp_msg.id      = lnkbank_pkg::id_t'(i);
        exp_msg.payload = model_q[i][0];
      end
    end
    check_valid(exp_valid, o_out_valid);
    // Refused when all slots are taken or a message leaves
    exp_ready = i_in_valid && held < `LNKBANK_DEPTH && !(exp_valid && i_out_ready);
    check_ready(exp_ready, o_in_ready);
    if (exp_valid && i_out_ready) begin
      check_msg("o_out_msg", exp_msg, o_out_msg);
      void'(model_q[exp_msg.id].pop_front());
      seen.push_back(o_out_msg);
      held--;
    end
    last_push    = i_in_valid && o_in_ready;
    last_push_id = i_in_msg.id;
    if (last_push) begin
      model_q[i_in_msg.id].push_back(i_in_msg.payload);
      held++;
    end
  endtask

  task automatic run_cycle(input logic valid, input lnkbank_pkg::msg_t msg, input logic ready);
    @(posedge clk_i);
    #1;
    i_in_valid  = valid;
    i_in_msg    = msg;
    i_out_ready = ready;
    @(negedge clk_i);
    observe_cycle();
  endtask

  // Empty the bank and match the phase output against its E lines
  task automatic drain_and_compare(input int unsigned phase);
    int unsigned k;
    while (held != 0) begin
      run_cycle(1'b0, '0, 1'b1);
    end
    k = 0;
    foreach (expects[n]) begin
      if (expects[n].phase == phase) begin
        if (k >= seen.size()) begin
          fail_run($sformatf("Phase %0d delivered only %0d messages", phase, seen.size()));
        end
        check_msg($sformatf("o_out_msg[%0d]", k), expects[n].msg, seen[k]);
        k++;
      end
    end
    if (k != 0 && k != seen.size()) begin
      fail_run($sformatf("Phase %0d delivered %0d messages, %0d were listed",
                         phase, seen.size(), k));
    end
    seen.delete();
  endtask

  task automatic replay_vectors();
    int unsigned gaps;
    for (int n = 0; n < drives.size(); n++) begin
      if (drives[n].phase == RANDOM_PHASE) begin
        gaps = $urandom % 3;
        repeat (gaps) begin
          run_cycle(1'b0, '0, 1'($urandom % 2));
        end
      end
      run_cycle(drives[n].valid, drives[n].msg, drives[n].ready);
      if (n == drives.size() - 1 || drives[n + 1].phase != drives[n].phase) begin
        drain_and_compare(drives[n].phase);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h9f8d_f728));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    i_in_valid   = 1'b0;
    i_in_msg     = '0;
    i_out_ready  = 1'b0;
    held         = 0;
    last_push    = 1'b0;
    last_push_id = '0;
    loaded       = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle bank straight after reset
    @(negedge clk_i);
    check_valid(1'b0, o_out_valid);
    check_ready(i_in_valid, o_in_ready);
    replay_vectors();
    if (held == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run($sformatf("%0d accepted messages were never delivered", held));
    end
  end

  // Budget of 40 cycles per vector line plus slack for reset and drains
  initial begin
    wait (loaded === 1'b1);
    #(CLK_NS * (40 * line_count + 200 + RESET_CYCLES));
    fail_run($sformatf("Watchdog expired at %0d ns, the run did not finish", $time));
  end

endmodule

//--- sim/lnkbank_vectors.txt
# D phase in_valid id payload(hex) out_ready : one cycle of stimulus
# E phase id payload(hex) : next expected output of that phase
# Phase 1, first push right after reset
D 1 0 0 00 0
D 1 1 2 11 0
E 1 2 11
# Phase 2, order within one identifier
D 2 1 1 20 0
D 2 1 1 21 0
D 2 0 0 00 1
D 2 1 1 22 0
D 2 1 1 23 0
E 2 1 20
E 2 1 21
E 2 1 22
E 2 1 23
# Phase 3, loaded under back-pressure, drained lowest id first
D 3 1 2 30 0
D 3 1 0 31 0
D 3 1 1 32 0
D 3 1 3 33 0
D 3 1 0 34 0
D 3 1 2 35 0
E 3 0 31
E 3 0 34
E 3 1 32
E 3 2 30
E 3 2 35
E 3 3 33
# Phase 4, full bank refuses, one release makes room
D 4 1 1 40 0
D 4 1 1 41 0
D 4 1 0 42 0
D 4 1 2 43 0
D 4 1 3 44 0
D 4 1 0 45 0
D 4 1 1 46 0
D 4 1 2 47 0
D 4 1 3 4f 0
D 4 0 0 00 1
D 4 1 0 48 0
# Phase 5, mixed traffic with random idle gaps
D 5 1 3 50 0
D 5 1 1 51 1
D 5 1 0 52 0
D 5 1 3 53 1
D 5 1 2 54 1
D 5 1 0 55 0
D 5 0 0 00 1
D 5 1 1 56 1
D 5 1 3 57 0
D 5 1 2 58 1

//--- flist.f
+incdir+common
+incdir+sim
common/lnkbank_pkg.sv
rtl/lnkbank_ram.sv
lnkbank/lnkbank_free_slots.sv
lnkbank/lnkbank_queue_ptrs.sv
lnkbank/lnkbank_release_arb.sv
lnkbank/lnkbank_top.sv
sim/tb_lnkbank.sv

//--- Makefile
# Verilator build and run of the message bank testbench
# The exit status of make test is the pass or fail of the run

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f \
		--top-module tb_lnkbank -Mdir obj_dir
	./obj_dir/Vtb_lnkbank

clean:
	rm -rf obj_dir
